//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt,
        alu_lui
    } alu_op_e;

    // one decoded instruction as it arrives from decode
    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        use_imm;
        logic [31:0] imm;
    } decoded_inst_t;

    // slot 0 is always valid, slot 0 is the older one
    typedef struct packed {
        logic          slot1_valid;
        decoded_inst_t inst1;
        decoded_inst_t inst0;
    } issue_pair_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     op;
        logic [4:0]  rd;
        logic [31:0] src_a;
        logic [31:0] src_b;
    } exe_inst_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] result;
    } exe_result_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } commit_t;

    function automatic logic [31:0] alu_compute(
        input alu_op_e     op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            alu_sll: r = a << b[4:0];
            alu_srl: r = a >> b[4:0];
            alu_slt: r = {31'd0, $signed(a) < $signed(b)};
            alu_lui: r = b << 12;
            default: r = 32'd0;
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire         aclk,
    input  wire  [4:0]  raddr0,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    input  wire  [4:0]  raddr3,
    output logic [31:0] rdata0,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    output logic [31:0] rdata3,
    input  wire         we0,
    input  wire  [4:0]  waddr0,
    input  wire  [31:0] wdata0,
    input  wire         we1,
    input  wire  [4:0]  waddr1,
    input  wire  [31:0] wdata1,
    input  wire  [4:0]  dbg_raddr,
    output logic [31:0] dbg_rdata
);

    logic [31:0] regs [32];

    function automatic logic [31:0] rd_reg(input logic [4:0] addr);
        return (addr == 5'd0) ? 32'd0 : regs[addr];
    endfunction

    // port 1 is written last so it wins on the same address
    always_ff @(posedge aclk) begin
        if (we0 && waddr0 != 5'd0) begin
            regs[waddr0] <= wdata0;
        end
        if (we1 && waddr1 != 5'd0) begin
            regs[waddr1] <= wdata1;
        end
    end

    assign rdata0    = rd_reg(raddr0);
    assign rdata1    = rd_reg(raddr1);
    assign rdata2    = rd_reg(raddr2);
    assign rdata3    = rd_reg(raddr3);
    assign dbg_rdata = rd_reg(dbg_raddr);

endmodule

`default_nettype wire

//--- hw/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  wire                        aclk,
    input  wire                        rst,
    input  wire                        in_valid,
    input  wire core_pkg::issue_pair_t in_pair,
    output logic                       in_allowin,
    input  wire                        es_allowin,
    output logic                       es_valid0,
    output logic                       es_valid1,
    output core_pkg::exe_inst_t        es_inst0,
    output core_pkg::exe_inst_t        es_inst1,
    output logic [4:0]                 rf_raddr0,
    output logic [4:0]                 rf_raddr1,
    output logic [4:0]                 rf_raddr2,
    output logic [4:0]                 rf_raddr3,
    input  wire  [31:0]                rf_rdata0,
    input  wire  [31:0]                rf_rdata1,
    input  wire  [31:0]                rf_rdata2,
    input  wire  [31:0]                rf_rdata3,
    input  wire                        fwd_valid0,
    input  wire                        fwd_valid1,
    input  wire                        fwd_valid2,
    input  wire                        fwd_valid3,
    input  wire core_pkg::exe_result_t fwd0,
    input  wire core_pkg::exe_result_t fwd1,
    input  wire core_pkg::exe_result_t fwd2,
    input  wire core_pkg::exe_result_t fwd3
);
    import core_pkg::*;

    // in st_slot1 slot 0 already went out and slot 1 waits alone
    typedef enum logic {st_pair, st_slot1} issue_state_e;

    issue_state_e  state;
    logic          is_valid;
    issue_pair_t   is_pair;
    decoded_inst_t head;
    decoded_inst_t tail;
    logic          dep;
    logic          last;
    logic [3:0]    fwd_vld;
    exe_result_t   fwd_src [4];
    logic [31:0]   head_rj;
    logic [31:0]   head_rk;
    logic [31:0]   tail_rj;
    logic [31:0]   tail_rk;

    // index 0 is the youngest producer and wins
    function automatic logic [31:0] fwd_pick(
        input logic [4:0]  addr,
        input logic [31:0] rf_val,
        input logic [3:0]  vld,
        input exe_result_t src [4]
    );
        logic [31:0] val;
        val = rf_val;
        for (int i = 3; i >= 0; i--) begin
            if (vld[i] && src[i].rd == addr && addr != 5'd0) begin
                val = src[i].result;
            end
        end
        return val;
    endfunction

    assign fwd_vld    = {fwd_valid3, fwd_valid2, fwd_valid1, fwd_valid0};
    assign fwd_src[0] = fwd0;
    assign fwd_src[1] = fwd1;
    assign fwd_src[2] = fwd2;
    assign fwd_src[3] = fwd3;

    assign head = (state == st_slot1) ? is_pair.inst1 : is_pair.inst0;
    assign tail = is_pair.inst1;

    // slot 1 reading slot 0's result forces a split
    assign dep = is_pair.slot1_valid && is_pair.inst0.rd != 5'd0
              && (tail.rj == is_pair.inst0.rd
                  || (!tail.use_imm && tail.rk == is_pair.inst0.rd));
    assign last = (state == st_slot1) || !dep;

    assign in_allowin = !is_valid || (es_allowin && last);

    assign rf_raddr0 = head.rj;
    assign rf_raddr1 = head.rk;
    assign rf_raddr2 = tail.rj;
    assign rf_raddr3 = tail.rk;

    assign head_rj = fwd_pick(head.rj, rf_rdata0, fwd_vld, fwd_src);
    assign head_rk = fwd_pick(head.rk, rf_rdata1, fwd_vld, fwd_src);
    assign tail_rj = fwd_pick(tail.rj, rf_rdata2, fwd_vld, fwd_src);
    assign tail_rk = fwd_pick(tail.rk, rf_rdata3, fwd_vld, fwd_src);

    assign es_valid0 = is_valid && es_allowin;
    assign es_valid1 = is_valid && es_allowin && state == st_pair
                    && is_pair.slot1_valid && !dep;

    assign es_inst0 = '{pc: head.pc, op: head.op, rd: head.rd, src_a: head_rj,
                        src_b: head.use_imm ? head.imm : head_rk};
    assign es_inst1 = '{pc: tail.pc, op: tail.op, rd: tail.rd, src_a: tail_rj,
                        src_b: tail.use_imm ? tail.imm : tail_rk};

    always_ff @(posedge aclk) begin
        if (rst) begin
            is_valid <= 1'b0;
            state    <= st_pair;
        end else if (in_allowin) begin
            is_valid <= in_valid;
            state    <= st_pair;
        end else if (is_valid && es_allowin) begin
            state <= st_slot1;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_allowin) begin
            is_pair <= in_pair;
        end
    end

endmodule

`default_nettype wire

//--- hw/exm_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exm_stage (
    input  wire                        aclk,
    input  wire                        rst,
    output logic                       es_allowin,
    input  wire                        ws_allowin,
    input  wire                        ds_valid,
    input  wire core_pkg::exe_inst_t   ds_inst,
    output logic                       es_to_ws_valid,
    output core_pkg::exe_result_t      es_to_ws_bus
);
    import core_pkg::*;

    logic        es_valid;
    exe_inst_t   es_inst;
    logic [31:0] alu_result;

    // single-cycle ALU so a held slot only waits on writeback
    assign es_allowin     = !es_valid || ws_allowin;
    assign es_to_ws_valid = es_valid;

    always_ff @(posedge aclk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (es_allowin && ds_valid) begin
            es_inst <= ds_inst;
        end
    end

    assign alu_result = alu_compute(es_inst.op, es_inst.src_a, es_inst.src_b);

    assign es_to_ws_bus = '{pc: es_inst.pc, rd: es_inst.rd, result: alu_result};

endmodule

`default_nettype wire

//--- hw/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
    input  wire                        aclk,
    input  wire                        rst,
    input  wire                        es_to_ws_valid0,
    input  wire                        es_to_ws_valid1,
    input  wire core_pkg::exe_result_t es_to_ws_bus0,
    input  wire core_pkg::exe_result_t es_to_ws_bus1,
    output logic                       ws_allowin,
    output logic                       ws_fwd_valid0,
    output logic                       ws_fwd_valid1,
    output core_pkg::exe_result_t      ws_fwd0,
    output core_pkg::exe_result_t      ws_fwd1,
    output logic                       rf_we0,
    output logic                       rf_we1,
    output logic [4:0]                 rf_waddr0,
    output logic [4:0]                 rf_waddr1,
    output logic [31:0]                rf_wdata0,
    output logic [31:0]                rf_wdata1,
    output logic                       trace_valid,
    input  wire                        trace_ready,
    output core_pkg::commit_t          trace0,
    output core_pkg::commit_t          trace1,
    output logic                       trace1_valid
);
    import core_pkg::*;

    logic        ws_valid0;
    logic        ws_valid1;
    exe_result_t ws_bus0;
    exe_result_t ws_bus1;
    logic        retire;

    // slot 1 never holds without slot 0
    assign retire     = ws_valid0 && trace_ready;
    assign ws_allowin = !ws_valid0 || trace_ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            ws_valid0 <= 1'b0;
            ws_valid1 <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid0 <= es_to_ws_valid0;
            ws_valid1 <= es_to_ws_valid1;
        end
    end

    always_ff @(posedge aclk) begin
        if (ws_allowin && es_to_ws_valid0) begin
            ws_bus0 <= es_to_ws_bus0;
        end
        if (ws_allowin && es_to_ws_valid1) begin
            ws_bus1 <= es_to_ws_bus1;
        end
    end

    // regfile write lands on the retire edge
    assign rf_we0    = retire;
    assign rf_we1    = retire && ws_valid1;
    assign rf_waddr0 = ws_bus0.rd;
    assign rf_waddr1 = ws_bus1.rd;
    assign rf_wdata0 = ws_bus0.result;
    assign rf_wdata1 = ws_bus1.result;

    assign ws_fwd_valid0 = ws_valid0;
    assign ws_fwd_valid1 = ws_valid1;
    assign ws_fwd0       = ws_bus0;
    assign ws_fwd1       = ws_bus1;

    assign trace_valid  = ws_valid0;
    assign trace1_valid = ws_valid1;
    assign trace0 = '{pc: ws_bus0.pc, wnum: ws_bus0.rd, wdata: ws_bus0.result};
    assign trace1 = '{pc: ws_bus1.pc, wnum: ws_bus1.rd, wdata: ws_bus1.result};

endmodule

`default_nettype wire

//--- hw/backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module backend_top (
    input  wire                        aclk,
    input  wire                        rst,
    input  wire                        in_valid,
    input  wire core_pkg::issue_pair_t in_pair,
    output logic                       in_allowin,
    output logic                       trace_valid,
    input  wire                        trace_ready,
    output core_pkg::commit_t          trace0,
    output core_pkg::commit_t          trace1,
    output logic                       trace1_valid,
    input  wire  [4:0]                 dbg_reg_num,
    output logic [31:0]                dbg_reg_data
);
    import core_pkg::*;

    logic        es_allowin;
    logic        ws_allowin;
    logic        ds_to_es_valid0;
    logic        ds_to_es_valid1;
    exe_inst_t   ds_to_es_inst0;
    exe_inst_t   ds_to_es_inst1;
    logic        es_to_ws_valid0;
    logic        es_to_ws_valid1;
    exe_result_t es_to_ws_bus0;
    exe_result_t es_to_ws_bus1;
    logic        ws_fwd_valid0;
    logic        ws_fwd_valid1;
    exe_result_t ws_fwd0;
    exe_result_t ws_fwd1;
    logic [4:0]  rf_raddr0;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [4:0]  rf_raddr3;
    logic [31:0] rf_rdata0;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] rf_rdata3;
    logic        rf_we0;
    logic        rf_we1;
    logic [4:0]  rf_waddr0;
    logic [4:0]  rf_waddr1;
    logic [31:0] rf_wdata0;
    logic [31:0] rf_wdata1;

    // forwarding priority runs from execute slot 1 down to writeback slot 0
    issue_stage issue_stage (
        .aclk       (aclk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_pair    (in_pair),
        .in_allowin (in_allowin),
        .es_allowin (es_allowin),
        .es_valid0  (ds_to_es_valid0),
        .es_valid1  (ds_to_es_valid1),
        .es_inst0   (ds_to_es_inst0),
        .es_inst1   (ds_to_es_inst1),
        .rf_raddr0  (rf_raddr0),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_raddr3  (rf_raddr3),
        .rf_rdata0  (rf_rdata0),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .rf_rdata3  (rf_rdata3),
        .fwd_valid0 (es_to_ws_valid1),
        .fwd_valid1 (es_to_ws_valid0),
        .fwd_valid2 (ws_fwd_valid1),
        .fwd_valid3 (ws_fwd_valid0),
        .fwd0       (es_to_ws_bus1),
        .fwd1       (es_to_ws_bus0),
        .fwd2       (ws_fwd1),
        .fwd3       (ws_fwd0)
    );

    exm_stage exm_stage0 (
        .aclk           (aclk),
        .rst            (rst),
        .es_allowin     (es_allowin),
        .ws_allowin     (ws_allowin),
        .ds_valid       (ds_to_es_valid0),
        .ds_inst        (ds_to_es_inst0),
        .es_to_ws_valid (es_to_ws_valid0),
        .es_to_ws_bus   (es_to_ws_bus0)
    );

    // slot 1 moves in lockstep with slot 0 and follows its allowin
    exm_stage exm_stage1 (
        .aclk           (aclk),
        .rst            (rst),
        .es_allowin     (),
        .ws_allowin     (ws_allowin),
        .ds_valid       (ds_to_es_valid1),
        .ds_inst        (ds_to_es_inst1),
        .es_to_ws_valid (es_to_ws_valid1),
        .es_to_ws_bus   (es_to_ws_bus1)
    );

    wb_stage wb_stage (
        .aclk            (aclk),
        .rst             (rst),
        .es_to_ws_valid0 (es_to_ws_valid0),
        .es_to_ws_valid1 (es_to_ws_valid1),
        .es_to_ws_bus0   (es_to_ws_bus0),
        .es_to_ws_bus1   (es_to_ws_bus1),
        .ws_allowin      (ws_allowin),
        .ws_fwd_valid0   (ws_fwd_valid0),
        .ws_fwd_valid1   (ws_fwd_valid1),
        .ws_fwd0         (ws_fwd0),
        .ws_fwd1         (ws_fwd1),
        .rf_we0          (rf_we0),
        .rf_we1          (rf_we1),
        .rf_waddr0       (rf_waddr0),
        .rf_waddr1       (rf_waddr1),
        .rf_wdata0       (rf_wdata0),
        .rf_wdata1       (rf_wdata1),
        .trace_valid     (trace_valid),
        .trace_ready     (trace_ready),
        .trace0          (trace0),
        .trace1          (trace1),
        .trace1_valid    (trace1_valid)
    );

    regfile regfile (
        .aclk      (aclk),
        .raddr0    (rf_raddr0),
        .raddr1    (rf_raddr1),
        .raddr2    (rf_raddr2),
        .raddr3    (rf_raddr3),
        .rdata0    (rf_rdata0),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .rdata3    (rf_rdata3),
        .we0       (rf_we0),
        .waddr0    (rf_waddr0),
        .wdata0    (rf_wdata0),
        .we1       (rf_we1),
        .waddr1    (rf_waddr1),
        .wdata1    (rf_wdata1),
        .dbg_raddr (dbg_reg_num),
        .dbg_rdata (dbg_reg_data)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic aclk
);

    // 4 ns period
    localparam int half_period = 2;

    initial begin
        aclk = 1'b0;
        forever begin
            #half_period aclk = ~aclk;
        end
    end

endmodule

`default_nettype wire

//--- test/backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module backend_tb;
    import core_pkg::*;

    localparam int unsigned seed_value      = 32'h333e_283a;
    localparam int          cycles_per_case = 8;
    localparam int          cycles_margin   = 200;
    localparam string       case_file       = "test/backend_cases.txt";

    // one retirement as the trace should show it
    typedef struct packed {
        logic    has1;
        commit_t c1;
        commit_t c0;
    } retire_t;

    logic        aclk;
    logic        rst;
    logic        in_valid;
    issue_pair_t in_pair;
    logic        in_allowin;
    logic        trace_valid;
    logic        trace_ready;
    commit_t     trace0;
    commit_t     trace1;
    logic        trace1_valid;
    logic [4:0]  dbg_reg_num;
    logic [31:0] dbg_reg_data;

    issue_pair_t pairs [$];
    int          pair_pct [$];
    retire_t     exp_q [$];
    logic [31:0] model_regs [32];
    logic [31:0] known;
    int          value_errors;
    int          other_errors;
    int          timeout_limit;
    int          cycle_cnt;

    tb_clock clk_gen (
        .aclk (aclk)
    );

    backend_top uut (
        .aclk         (aclk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_pair      (in_pair),
        .in_allowin   (in_allowin),
        .trace_valid  (trace_valid),
        .trace_ready  (trace_ready),
        .trace0       (trace0),
        .trace1       (trace1),
        .trace1_valid (trace1_valid),
        .dbg_reg_num  (dbg_reg_num),
        .dbg_reg_data (dbg_reg_data)
    );

    function automatic logic [31:0] model_alu(
        input alu_op_e     op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a + ~b + 32'd1;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            alu_sll: r = a << b[4:0];
            alu_srl: r = a >> b[4:0];
            // differing signs decide it and equal signs compare magnitude
            alu_slt: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            alu_lui: r = {b[19:0], 12'd0};
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic decoded_inst_t make_inst(
        input int          op,
        input int          rd,
        input int          rj,
        input int          rk,
        input int          use_imm,
        input logic [31:0] imm,
        input logic [31:0] pc
    );
        decoded_inst_t inst;
        inst.pc      = pc;
        inst.op      = alu_op_e'(op[3:0]);
        inst.rd      = rd[4:0];
        inst.rj      = rj[4:0];
        inst.rk      = rk[4:0];
        inst.use_imm = use_imm[0];
        inst.imm     = imm;
        return inst;
    endfunction

    task automatic check_commit(input string name, input commit_t exp, input commit_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected pc %h wnum %h wdata %h, got pc %h wnum %h wdata %h",
                     name, exp.pc, exp.wnum, exp.wdata, act.pc, act.wnum, act.wdata);
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // architectural effect of one instruction in program order
    task automatic run_model(input decoded_inst_t inst, output commit_t c);
        logic [31:0] a;
        logic [31:0] b;
        if (!known[inst.rj] || (!inst.use_imm && !known[inst.rk])) begin
            other_errors++;
            $display("case at pc %h reads a register that was never written", inst.pc);
        end
        a = model_regs[inst.rj];
        b = inst.use_imm ? inst.imm : model_regs[inst.rk];
        c.pc    = inst.pc;
        c.wnum  = inst.rd;
        c.wdata = model_alu(inst.op, a, b);
        if (inst.rd != 5'd0) begin
            model_regs[inst.rd] = c.wdata;
            known[inst.rd]      = 1'b1;
        end
    endtask

    task automatic record_pair(input issue_pair_t p);
        retire_t first;
        retire_t second;
        logic    split;
        split = p.slot1_valid && p.inst0.rd != 5'd0
             && (p.inst1.rj == p.inst0.rd
                 || (!p.inst1.use_imm && p.inst1.rk == p.inst0.rd));
        first  = '0;
        second = '0;
        run_model(p.inst0, first.c0);
        if (!p.slot1_valid) begin
            exp_q.push_back(first);
        end else if (split) begin
            // slot 1 retires alone one issue later
            run_model(p.inst1, second.c0);
            exp_q.push_back(first);
            exp_q.push_back(second);
        end else begin
            run_model(p.inst1, first.c1);
            first.has1 = 1'b1;
            exp_q.push_back(first);
        end
    endtask

    task automatic match_retirement();
        retire_t exp;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("commit of pc %h appeared when no commit was expected", trace0.pc);
            return;
        end
        exp = exp_q.pop_front();
        check_commit("trace0", exp.c0, trace0);
        check_flag("trace1_valid", exp.has1, trace1_valid);
        if (exp.has1 && trace1_valid) begin
            check_commit("trace1", exp.c1, trace1);
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          sect;
        int          fld [11];
        logic [31:0] imm0;
        logic [31:0] imm1;
        logic [31:0] pc;
        string       line;
        issue_pair_t p;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open %s", case_file);
            return;
        end
        sect = 0;
        pc   = 32'h1c00_0000;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0) begin
                continue;
            end
            if (line.getc(0) == "s") begin
                if ($sscanf(line, "s %d", sect) != 1) begin
                    other_errors++;
                    $display("bad section line in case file: %s", line);
                end
            end else if (line.getc(0) == "p") begin
                n = $sscanf(line, "p %d %d %d %d %d %h %d %d %d %d %d %d %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], imm0, fld[5],
                            fld[6], fld[7], fld[8], fld[9], fld[10], imm1);
                if (n != 13) begin
                    other_errors++;
                    $display("bad pair line in case file: %s", line);
                    continue;
                end
                p             = '0;
                p.slot1_valid = (fld[5] != 0);
                p.inst0       = make_inst(fld[0], fld[1], fld[2], fld[3], fld[4], imm0, pc);
                if (p.slot1_valid) begin
                    p.inst1 = make_inst(fld[6], fld[7], fld[8], fld[9], fld[10], imm1,
                                        pc + 32'd4);
                end
                pc = pc + (p.slot1_valid ? 32'd8 : 32'd4);
                pairs.push_back(p);
                pair_pct.push_back(sect);
            end
        end
        $fclose(fd);
    endtask

    initial begin : main
        int sent;
        int pct;
        void'($urandom(seed_value));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_pair      = '0;
        trace_ready  = 1'b0;
        dbg_reg_num  = 5'd0;
        value_errors = 0;
        other_errors = 0;
        known        = 32'h1;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        load_cases();
        if (pairs.size() == 0) begin
            other_errors++;
            $display("case file holds no instruction pairs");
        end
        timeout_limit = pairs.size() * cycles_per_case + cycles_margin;

        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        #1;
        check_flag("trace_valid", 1'b0, trace_valid);
        check_flag("in_allowin", 1'b1, in_allowin);

        sent = 0;
        pct  = 0;
        while (sent < pairs.size() || exp_q.size() > 0) begin
            @(negedge aclk);
            // the last section's stall rate also covers the drain
            if (sent < pairs.size()) begin
                pct = pair_pct[sent];
            end
            trace_ready = ($urandom_range(99) >= pct);
            if (sent < pairs.size()) begin
                in_valid = 1'b1;
                in_pair  = pairs[sent];
            end else begin
                in_valid = 1'b0;
                in_pair  = '0;
            end
            #1;
            if (trace_valid && trace_ready) begin
                match_retirement();
            end
            if (in_valid && in_allowin) begin
                record_pair(pairs[sent]);
                sent++;
            end
        end

        @(negedge aclk);
        in_valid    = 1'b0;
        trace_ready = 1'b1;
        for (int r = 0; r < 32; r++) begin
            @(negedge aclk);
            dbg_reg_num = r[4:0];
            #1;
            if (trace_valid) begin
                other_errors++;
                $display("extra commit of pc %h after all expected commits", trace0.pc);
            end
            if (known[r]) begin
                check_reg($sformatf("dbg_reg_data r%0d", r), model_regs[r], dbg_reg_data);
            end
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        #1;
        while (cycle_cnt < timeout_limit) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_cnt);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/backend_cases.txt
# s pct: new section, trace_ready low on pct percent of cycles
# p op0 rd0 rj0 rk0 u0 imm0 v1 op1 rd1 rj1 rk1 u1 imm1 (imm hex) op 0..8 add sub and or xor sll srl slt lui
s 0
p 0 1 0 0 1 00000011 1 0 2 0 0 1 ffffff80
p 0 3 0 0 1 12345678 1 0 4 0 0 1 0000000f
p 0 5 0 0 1 80000000 1 0 6 0 0 1 00000005
p 0 7 0 0 1 deadbeef 1 0 8 0 0 1 7fffffff
p 1 9 3 1 0 0 1 2 10 3 4 0 0
p 3 11 1 2 0 0 1 4 12 3 7 0 0
p 5 13 3 6 0 0 1 6 14 5 6 0 0
p 7 15 2 1 0 0 1 7 16 1 2 0 0
p 8 17 0 0 1 000abcde 1 5 18 4 0 1 0000001f
p 0 0 3 4 0 0 1 4 19 0 7 0 0
p 0 20 0 0 1 00000001 0 0 0 0 0 0 0
# back-to-back dependencies
p 0 21 1 3 0 0 1 1 22 4 5 0 0
p 0 23 21 22 0 0 1 4 24 21 1 0 0
p 3 25 23 24 0 0 1 2 26 21 0 1 0000ffff
p 1 27 25 26 0 0 1 0 28 23 0 1 00000100
# slot 1 reads slot 0, then both slots write r12
p 0 29 1 1 0 0 1 0 30 29 29 0 0
p 4 31 29 30 0 0 1 5 1 31 0 1 00000004
p 8 2 0 0 1 00000123 1 3 3 2 0 1 00000456
p 0 4 1 2 0 0 1 1 5 6 4 0 0
p 0 12 1 2 0 0 1 1 12 3 4 0 0
s 30
p 0 7 7 8 0 0 1 1 8 7 8 0 0
p 4 9 7 8 0 0 1 6 10 9 0 1 00000003
p 7 11 9 10 0 0 1 3 13 11 10 0 0
p 0 14 13 11 0 0 1 2 15 14 12 0 0
p 5 16 15 0 1 00000002 1 0 17 16 13 0 0
p 0 18 16 17 0 0 1 1 19 15 14 0 0
s 60
p 8 20 0 0 1 00000fff 1 0 21 19 18 0 0
p 3 22 20 21 0 0 1 4 23 20 22 0 0
p 0 24 22 23 0 0 0 0 0 0 0 0 0
p 6 25 24 0 1 00000004 1 7 26 25 24 0 0
p 0 6 26 25 0 0 1 0 6 6 5 0 0
p 1 27 6 1 0 0 1 2 28 6 27 0 0

//--- vlog.f
hw/core_pkg.sv
hw/regfile.sv
hw/issue_stage.sv
hw/exm_stage.sv
hw/wb_stage.sv
hw/backend_top.sv
test/tb_clock.sv
test/backend_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module backend_tb -Mdir obj_dir -o backend_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/backend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in sim.log"
exit 1
